// ==== hdl/ppu_tx_pkg.sv ====
// Shared types, field positions and constants of the transmit-side post-processing unit
package ppu_tx_pkg;

  // ----------------------------------------------------------------------
  // Widths and plain vector types
  // ----------------------------------------------------------------------
  localparam int COLOR_W     = 8;
  localparam int SYNC_W      = 4;
  localparam int CFG_W       = 12;
  localparam int POS_CNT_W   = 8;
  localparam int CFG_FILTER_W = 3;
  localparam int CFG_LM240_W = 2;

  typedef logic [COLOR_W-1:0]     color_t;
  // Active low, {vsync, clamp, hsync, csync}
  typedef logic [SYNC_W-1:0]      sync_t;
  typedef logic [1:0]             linemult_t;
  typedef logic [1:0]             filter_t;
  typedef logic [CFG_W-1:0]       cfg_word_t;
  typedef logic [POS_CNT_W-1:0]   pos_cnt_t;
  // Matrix products and signed chroma sums
  typedef logic [2*COLOR_W-1:0]   prod_t;
  typedef logic signed [2*COLOR_W:0] csum_t;

  // Sync bit positions inside sync_t
  localparam int SYNC_V_BIT = 3;
  localparam int SYNC_H_BIT = 1;
  localparam int SYNC_C_BIT = 0;

  // ----------------------------------------------------------------------
  // Raw configuration word layout, bit 11 is spare
  // ----------------------------------------------------------------------
  localparam int CFG_TESTPAT_BIT      = 0;
  localparam int CFG_SWAP_RB_BIT      = 1;
  localparam int CFG_YPBPR_BIT        = 2;
  localparam int CFG_RGSB_BIT         = 3;
  // Filter field, 0 selects auto
  localparam int CFG_FILTER_LSB       = 4;
  localparam int CFG_LM240_LSB        = 7;
  localparam int CFG_LX480_BIT        = 9;
  localparam int CFG_USE_VGA_SYNC_BIT = 10;

  // Pixel as it moves between the stages
  typedef struct packed {
    sync_t  sync;
    color_t red;
    color_t green;
    color_t blue;
  } vdata_t;

  // Mode info from the input domain
  typedef struct packed {
    logic palmode;
    logic mode_480i;
  } vinfo_t;

  // Decoded settings, also carries the mode info used for status
  typedef struct packed {
    logic      testpat;
    logic      swap_rb;
    logic      en_ypbpr;
    logic      en_rgsb;
    logic      use_vga_sync;
    linemult_t linemult;
    filter_t   filter;
    logic      filter_auto;
    vinfo_t    vinfo;
  } cfg_dec_t;

  // Status word, lowest bit is spare and reads as zero
  typedef struct packed {
    logic      palmode;
    logic      mode_480i;
    linemult_t linemult;
    logic      en_ypbpr;
    logic      en_rgsb;
    filter_t   filter;
    logic      filter_auto;
    logic      spare;
  } ppu_state_t;

  // Checkerboard colours and the counter bit selecting the cell
  localparam color_t PAT_COLOR_HI = 8'hFF;
  localparam color_t PAT_COLOR_LO = 8'h10;
  localparam int     PAT_CELL_BIT = 3;

  // RGB to YPbPr coefficients, scaled by 256
  localparam color_t Y_KR       = 8'd77;
  localparam color_t Y_KG       = 8'd150;
  localparam color_t Y_KB       = 8'd29;
  localparam color_t PB_KR      = 8'd43;
  localparam color_t PB_KG      = 8'd85;
  localparam color_t PR_KG      = 8'd107;
  localparam color_t PR_KB      = 8'd21;
  localparam color_t CHROMA_OFS = 8'd128;

  localparam int VCONV_STAGES = 3;

endpackage

// ==== hdl/ppu_tx_cfg_ctrl.sv ====
// Configuration resync and decode with mode rules, status word and clock select
`timescale 1ns/1ns

module ppu_tx_cfg_ctrl (
  input  logic                   VCLK_Tx,
  input  logic                   nVRST_Tx,
  input  ppu_tx_pkg::cfg_word_t  cfg_i,
  input  ppu_tx_pkg::vinfo_t     vinfo_i,
  input  logic                   use_vpll_i,
  output ppu_tx_pkg::cfg_dec_t   cfg_o,
  output ppu_tx_pkg::ppu_state_t ppu_state_o,
  output ppu_tx_pkg::linemult_t  vclk_tx_select_o
);

  import ppu_tx_pkg::*;

  cfg_word_t cfg_s1, cfg_s2;
  vinfo_t    vinfo_s1, vinfo_s2;
  cfg_dec_t  cfg_d, cfg_q;

  logic [CFG_FILTER_W-1:0] filt_field;
  logic [CFG_LM240_W-1:0]  lm240;
  linemult_t               lm_next;

  // ----------------------------------------------------------------------
  // Two-flop resync from the menu and input domains
  // ----------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_s1   <= '0;
      cfg_s2   <= '0;
      vinfo_s1 <= '0;
      vinfo_s2 <= '0;
    end else begin
      cfg_s1   <= cfg_i;
      cfg_s2   <= cfg_s1;
      vinfo_s1 <= vinfo_i;
      vinfo_s2 <= vinfo_s1;
    end
  end

  // ----------------------------------------------------------------------
  // Decode of the synchronized word
  // ----------------------------------------------------------------------
  assign filt_field = cfg_s2[CFG_FILTER_LSB +: CFG_FILTER_W];
  assign lm240      = cfg_s2[CFG_LM240_LSB +: CFG_LM240_W];

  always_comb begin
    // Line multiplier from the first rule that matches
    if (cfg_s2[CFG_TESTPAT_BIT])
      lm_next = 2'd0;
    else if (vinfo_s2.mode_480i)
      lm_next = {1'b0, cfg_s2[CFG_LX480_BIT]};
    else if (vinfo_s2.palmode || !use_vpll_i)
      // Without the VPLL or in PAL an x3 request drops to x2 and code 3 to off
      lm_next = {1'b0, ^lm240};
    else
      lm_next = lm240;

    cfg_d.testpat      = cfg_s2[CFG_TESTPAT_BIT];
    cfg_d.swap_rb      = cfg_s2[CFG_SWAP_RB_BIT];
    cfg_d.en_ypbpr     = cfg_s2[CFG_YPBPR_BIT];
    cfg_d.en_rgsb      = cfg_s2[CFG_RGSB_BIT];
    cfg_d.use_vga_sync = cfg_s2[CFG_USE_VGA_SYNC_BIT];
    cfg_d.linemult     = lm_next;
    cfg_d.vinfo        = vinfo_s2;
    // Auto filter tracks the line multiplier
    cfg_d.filter_auto  = (filt_field == '0);
    if (cfg_d.filter_auto)
      cfg_d.filter = lm_next;
    else
      cfg_d.filter = filter_t'(filt_field - 3'd1);
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx)
      cfg_q <= '0;
    else
      cfg_q <= cfg_d;
  end

  // Status word straight from the decode register
  always_comb begin
    ppu_state_o.palmode     = cfg_q.vinfo.palmode;
    ppu_state_o.mode_480i   = cfg_q.vinfo.mode_480i;
    ppu_state_o.linemult    = cfg_q.linemult;
    ppu_state_o.en_ypbpr    = cfg_q.en_ypbpr;
    ppu_state_o.en_rgsb     = cfg_q.en_rgsb;
    ppu_state_o.filter      = cfg_q.filter;
    ppu_state_o.filter_auto = cfg_q.filter_auto;
    ppu_state_o.spare       = 1'b0;
  end

  assign cfg_o            = cfg_q;
  assign vclk_tx_select_o = cfg_q.linemult;

  // PAL seen at the resync output never yields x3 or above one cycle later
  a_pal_no_x3: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    vinfo_s2.palmode |=> (cfg_q.linemult inside {2'd0, 2'd1}));

endmodule

// ==== hdl/ppu_tx_pattern.sv ====
// Pixel and line position tracking with checkerboard test pattern substitution
`timescale 1ns/1ns

module ppu_tx_pattern (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  ppu_tx_pkg::cfg_dec_t cfg_i,
  input  ppu_tx_pkg::vdata_t   pixel_i,
  input  logic                 pixel_valid_i,
  output ppu_tx_pkg::vdata_t   pixel_o,
  output logic                 pixel_valid_o
);

  import ppu_tx_pkg::*;

  pos_cnt_t pix_cnt, line_cnt;
  logic     hs_low, vs_low, hs_low_prev;
  logic     cell_hi;
  color_t   pat_color;

  // Sync bits are active low
  assign hs_low = ~pixel_i.sync[SYNC_H_BIT];
  assign vs_low = ~pixel_i.sync[SYNC_V_BIT];

  // ----------------------------------------------------------------------
  // Position counters, only valid pixels count
  // ----------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_cnt     <= '0;
      line_cnt    <= '0;
      hs_low_prev <= 1'b0;
    end else if (pixel_valid_i) begin
      hs_low_prev <= hs_low;
      // Pixel count restarts during hsync
      if (hs_low)
        pix_cnt <= '0;
      else
        pix_cnt <= pix_cnt + 1'b1;
      // New line on the leading pixel of an hsync run, vsync clears
      if (vs_low)
        line_cnt <= '0;
      else if (hs_low && !hs_low_prev)
        line_cnt <= line_cnt + 1'b1;
    end
  end

  // Checker cell from counters before this pixel's update
  assign cell_hi   = pix_cnt[PAT_CELL_BIT] ^ line_cnt[PAT_CELL_BIT];
  assign pat_color = cell_hi ? PAT_COLOR_HI : PAT_COLOR_LO;

  // Output stage, one cycle
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx)
      pixel_valid_o <= 1'b0;
    else
      pixel_valid_o <= pixel_valid_i;
  end

  always_ff @(posedge VCLK_Tx) begin
    pixel_o.sync <= pixel_i.sync;
    if (cfg_i.testpat) begin
      pixel_o.red   <= pat_color;
      pixel_o.green <= pat_color;
      pixel_o.blue  <= pat_color;
    end else begin
      pixel_o.red   <= pixel_i.red;
      pixel_o.green <= pixel_i.green;
      pixel_o.blue  <= pixel_i.blue;
    end
  end

endmodule

// ==== hdl/ppu_tx_vconv.sv ====
// Three-stage RGB to YPbPr matrix with an equal-latency bypass
`timescale 1ns/1ns

module ppu_tx_vconv (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  ppu_tx_pkg::cfg_dec_t cfg_i,
  input  ppu_tx_pkg::vdata_t   pixel_i,
  input  logic                 pixel_valid_i,
  output ppu_tx_pkg::vdata_t   pixel_o,
  output logic                 pixel_valid_o
);

  import ppu_tx_pkg::*;

  // Arithmetic shift by 8, add offset, clip to a colour value
  function automatic color_t sat_chroma(input csum_t sum);
    csum_t t;
    t = (sum >>> COLOR_W) + $signed({1'b0, CHROMA_OFS});
    if (t < 0)
      return '0;
    else if (t > $signed(17'd255))
      return '1;
    else
      return t[COLOR_W-1:0];
  endfunction

  vdata_t                  px_q [VCONV_STAGES];
  logic [VCONV_STAGES-1:0] vld_q;

  prod_t y_r, y_g, y_b;
  prod_t pb_r, pb_g, pb_b;
  prod_t pr_r, pr_g, pr_b;
  prod_t y_sum;
  csum_t pb_sum, pr_sum;

  // ----------------------------------------------------------------------
  // Stage 1, coefficient products
  // ----------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx) begin
    y_r  <= Y_KR * pixel_i.red;
    y_g  <= Y_KG * pixel_i.green;
    y_b  <= Y_KB * pixel_i.blue;
    pb_r <= PB_KR * pixel_i.red;
    pb_g <= PB_KG * pixel_i.green;
    pb_b <= CHROMA_OFS * pixel_i.blue;
    pr_r <= CHROMA_OFS * pixel_i.red;
    pr_g <= PR_KG * pixel_i.green;
    pr_b <= PR_KB * pixel_i.blue;
  end

  // Stage 2, sums, chroma goes signed
  always_ff @(posedge VCLK_Tx) begin
    y_sum  <= y_r + y_g + y_b;
    pb_sum <= $signed({1'b0, pb_b}) - $signed({1'b0, pb_r}) - $signed({1'b0, pb_g});
    pr_sum <= $signed({1'b0, pr_r}) - $signed({1'b0, pr_g}) - $signed({1'b0, pr_b});
  end

  // ----------------------------------------------------------------------
  // Bypass line, sync rides along; stage 3 picks matrix or bypass colour
  // ----------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx) begin
    px_q[0] <= pixel_i;
    px_q[1] <= px_q[0];
    if (cfg_i.en_ypbpr) begin
      px_q[2].sync  <= px_q[1].sync;
      // Pr on red, Y on green, Pb on blue
      px_q[2].red   <= sat_chroma(pr_sum);
      px_q[2].green <= y_sum[2*COLOR_W-1:COLOR_W];
      px_q[2].blue  <= sat_chroma(pb_sum);
    end else begin
      px_q[2] <= px_q[1];
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx)
      vld_q <= '0;
    else
      vld_q <= {vld_q[VCONV_STAGES-2:0], pixel_valid_i};
  end

  assign pixel_o       = px_q[VCONV_STAGES-1];
  assign pixel_valid_o = vld_q[VCONV_STAGES-1];

  // Valid strobes must stay defined once out of reset
  a_vld_known: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !$isunknown(vld_q));

endmodule

// ==== hdl/ppu_tx_vout.sv ====
// Output register with red/blue exchange, composite sync and VGA-sync/filter pins
`timescale 1ns/1ns

module ppu_tx_vout (
  input  logic                           VCLK_Tx,
  input  logic                           nVRST_Tx,
  input  ppu_tx_pkg::cfg_dec_t           cfg_i,
  input  ppu_tx_pkg::vdata_t             pixel_i,
  input  logic                           pixel_valid_i,
  output logic [3*ppu_tx_pkg::COLOR_W-1:0] vd_o,
  output logic                           vd_valid_o,
  output logic [1:0]                     ncsync_o,
  output logic                           nvsync_or_f2_o,
  output logic                           nhsync_or_f1_o
);

  import ppu_tx_pkg::*;

  logic sync_on_color;

  // Sync on green or on Y
  assign sync_on_color = cfg_i.en_rgsb | cfg_i.en_ypbpr;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_valid_o     <= 1'b0;
      vd_o           <= '0;
      ncsync_o       <= 2'b00;
      nvsync_or_f2_o <= 1'b0;
      nhsync_or_f1_o <= 1'b0;
    end else begin
      vd_valid_o <= pixel_valid_i;
      // Everything else holds over gaps
      if (pixel_valid_i) begin
        if (cfg_i.swap_rb)
          vd_o <= {pixel_i.blue, pixel_i.green, pixel_i.red};
        else
          vd_o <= {pixel_i.red, pixel_i.green, pixel_i.blue};
        ncsync_o[1] <= pixel_i.sync[SYNC_C_BIT];
        ncsync_o[0] <= sync_on_color ? pixel_i.sync[SYNC_C_BIT] : 1'b0;
        // Shared pins carry VGA sync or the filter add-on select
        if (cfg_i.use_vga_sync) begin
          nvsync_or_f2_o <= pixel_i.sync[SYNC_V_BIT];
          nhsync_or_f1_o <= pixel_i.sync[SYNC_H_BIT];
        end else begin
          nvsync_or_f2_o <= cfg_i.filter[1];
          nhsync_or_f1_o <= cfg_i.filter[0];
        end
      end
    end
  end

  // Sync-on-colour pin stays low over pixels and gaps while plain RGB is selected
  a_csync0_off: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (!sync_on_color && !ncsync_o[0]) |=> !ncsync_o[0]);

endmodule

// ==== hdl/ppu_tx_top.sv ====
// Transmit-side post-processing top, config decode plus pattern, vconv and vout stages
`timescale 1ns/1ns

module ppu_tx_top (
  input  logic                             VCLK_Tx,
  input  logic                             nVRST_Tx,
  input  ppu_tx_pkg::vdata_t               pixel_i,
  input  logic                             pixel_valid_i,
  input  ppu_tx_pkg::cfg_word_t            cfg_i,
  input  ppu_tx_pkg::vinfo_t               vinfo_i,
  input  logic                             use_vpll_i,
  output logic [3*ppu_tx_pkg::COLOR_W-1:0] vd_o,
  output logic                             vd_valid_o,
  output logic [1:0]                       ncsync_o,
  output logic                             nvsync_or_f2_o,
  output logic                             nhsync_or_f1_o,
  output ppu_tx_pkg::ppu_state_t           ppu_state_o,
  output ppu_tx_pkg::linemult_t            vclk_tx_select_o
);

  import ppu_tx_pkg::*;

  cfg_dec_t cfg;
  vdata_t   pat_pixel, cv_pixel;
  logic     pat_valid, cv_valid;

  // ----------------------------------------------------------------------
  // Control, three cycles from cfg_i to decoded settings
  // ----------------------------------------------------------------------
  ppu_tx_cfg_ctrl cfg_ctrl_u (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .cfg_i            (cfg_i),
    .vinfo_i          (vinfo_i),
    .use_vpll_i       (use_vpll_i),
    .cfg_o            (cfg),
    .ppu_state_o      (ppu_state_o),
    .vclk_tx_select_o (vclk_tx_select_o)
  );

  // Datapath, 1 + 3 + 1 cycles
  ppu_tx_pattern pattern_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .pixel_o       (pat_pixel),
    .pixel_valid_o (pat_valid)
  );

  ppu_tx_vconv vconv_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg),
    .pixel_i       (pat_pixel),
    .pixel_valid_i (pat_valid),
    .pixel_o       (cv_pixel),
    .pixel_valid_o (cv_valid)
  );

  ppu_tx_vout vout_u (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .cfg_i          (cfg),
    .pixel_i        (cv_pixel),
    .pixel_valid_i  (cv_valid),
    .vd_o           (vd_o),
    .vd_valid_o     (vd_valid_o),
    .ncsync_o       (ncsync_o),
    .nvsync_or_f2_o (nvsync_or_f2_o),
    .nhsync_or_f1_o (nhsync_or_f1_o)
  );

endmodule

// ==== tests/ppu_tx_tb_ref.svh ====
// Reference model of the post-processing unit for pattern colour, YPbPr and config decode
`ifndef PPU_TX_TB_REF_SVH
`define PPU_TX_TB_REF_SVH

// Checkerboard cell from counter bit 3
function automatic logic [7:0] ref_pattern(input logic [7:0] pix, input logic [7:0] line);
  return (pix[3] != line[3]) ? 8'hFF : 8'h10;
endfunction

// Clip a signed result into 0..255
function automatic logic [7:0] clip_to_byte(input int v);
  if (v < 0)
    return 8'd0;
  if (v > 255)
    return 8'd255;
  return v[7:0];
endfunction

// Returns {Pr, Y, Pb} in red, green, blue order
function automatic logic [23:0] ref_ypbpr(input logic [7:0] r, input logic [7:0] g,
                                          input logic [7:0] b);
  int ri, gi, bi, y, pb, pr;
  ri = r;
  gi = g;
  bi = b;
  y  = (77 * ri + 150 * gi + 29 * bi) >>> 8;
  pb = ((128 * bi - 43 * ri - 85 * gi) >>> 8) + 128;
  pr = ((128 * ri - 107 * gi - 21 * bi) >>> 8) + 128;
  return {clip_to_byte(pr), clip_to_byte(y), clip_to_byte(pb)};
endfunction

// Status word {pal, 480i, linemult, ypbpr, rgsb, filter, auto, spare}
function automatic logic [9:0] ref_decode(input logic [11:0] cfg, input logic pal,
                                          input logic m480, input logic vpll);
  logic [1:0] lm240, lm, filt;
  logic [2:0] ff;
  logic       auto_f;
  lm240 = cfg[CFG_LM240_LSB +: 2];
  ff    = cfg[CFG_FILTER_LSB +: 3];
  if (cfg[CFG_TESTPAT_BIT])
    lm = 2'd0;
  else if (m480)
    lm = {1'b0, cfg[CFG_LX480_BIT]};
  else if (pal || !vpll)
    // x3 request is dropped, x2 stays
    lm = (lm240 == 2'd0 || lm240 == 2'd3) ? 2'd0 : 2'd1;
  else
    lm = lm240;
  auto_f = (ff == 3'd0);
  filt   = auto_f ? lm : ff[1:0] - 2'd1;
  return {pal, m480, lm, cfg[CFG_YPBPR_BIT], cfg[CFG_RGSB_BIT], filt, auto_f, 1'b0};
endfunction

`endif

// ==== tests/ppu_tx_tb.sv ====
// Self-checking testbench for the transmit-side post-processing unit against a reference model
`timescale 1ns/1ns

module ppu_tx_tb;

  import ppu_tx_pkg::*;

  `include "ppu_tx_tb_ref.svh"

  // Well above the roughly 7600 cycles of stimulus in all tests
  localparam int TIMEOUT_CYCLES = 12000;

  // Expected response of one output pixel
  typedef struct packed {
    logic [23:0] vd;
    logic [1:0]  ncsync;
    logic        nv;
    logic        nh;
  } exp_out_t;

  logic        VCLK_Tx;
  logic        nVRST_Tx;
  vdata_t      pixel_i;
  logic        pixel_valid_i;
  cfg_word_t   cfg_i;
  vinfo_t      vinfo_i;
  logic        use_vpll_i;
  logic [23:0] vd_o;
  logic        vd_valid_o;
  logic [1:0]  ncsync_o;
  logic        nvsync_or_f2_o;
  logic        nhsync_or_f1_o;
  ppu_state_t  ppu_state_o;
  linemult_t   vclk_tx_select_o;

  exp_out_t    exp_q[$];
  exp_out_t    exp_cur;
  logic [4:0]  vld_hist;
  int          cycle_cnt = 0;

  // Mirror of the configuration and of the position counters
  cfg_word_t   cur_cfg;
  vinfo_t      cur_vinfo;
  logic        cur_vpll;
  logic [7:0]  pix_pos, line_pos;
  logic        hs_prev;

  ppu_tx_top ppu_tx_top_i (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .pixel_i          (pixel_i),
    .pixel_valid_i    (pixel_valid_i),
    .cfg_i            (cfg_i),
    .vinfo_i          (vinfo_i),
    .use_vpll_i       (use_vpll_i),
    .vd_o             (vd_o),
    .vd_valid_o       (vd_valid_o),
    .ncsync_o         (ncsync_o),
    .nvsync_or_f2_o   (nvsync_or_f2_o),
    .nhsync_or_f1_o   (nhsync_or_f1_o),
    .ppu_state_o      (ppu_state_o),
    .vclk_tx_select_o (vclk_tx_select_o)
  );

  // 20 ns period
  always #10 VCLK_Tx = ~VCLK_Tx;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "stopping on first error");
    end
  endtask

  // Expected output for one input pixel under the current settings
  function automatic exp_out_t expected_output(input vdata_t px);
    exp_out_t   e;
    vdata_t     c;
    logic [9:0] st;
    logic [7:0] pat;
    st = ref_decode(cur_cfg, cur_vinfo.palmode, cur_vinfo.mode_480i, cur_vpll);
    c  = px;
    if (cur_cfg[CFG_TESTPAT_BIT]) begin
      pat     = ref_pattern(pix_pos, line_pos);
      c.red   = pat;
      c.green = pat;
      c.blue  = pat;
    end
    if (cur_cfg[CFG_YPBPR_BIT])
      {c.red, c.green, c.blue} = ref_ypbpr(c.red, c.green, c.blue);
    e.vd = cur_cfg[CFG_SWAP_RB_BIT] ? {c.blue, c.green, c.red} : {c.red, c.green, c.blue};
    // Sync on colour only with RGsB or YPbPr
    e.ncsync[1] = px.sync[SYNC_C_BIT];
    e.ncsync[0] = (cur_cfg[CFG_RGSB_BIT] | cur_cfg[CFG_YPBPR_BIT]) ? px.sync[SYNC_C_BIT] : 1'b0;
    if (cur_cfg[CFG_USE_VGA_SYNC_BIT])
      {e.nv, e.nh} = {px.sync[SYNC_V_BIT], px.sync[SYNC_H_BIT]};
    else
      {e.nv, e.nh} = st[3:2];
    return e;
  endfunction

  // Position counters by the pixel and line rules
  task automatic update_position(input sync_t s);
    logic hs_low, vs_low;
    hs_low   = !s[SYNC_H_BIT];
    vs_low   = !s[SYNC_V_BIT];
    pix_pos  = hs_low ? 8'd0 : pix_pos + 8'd1;
    if (vs_low)
      line_pos = 8'd0;
    else if (hs_low && !hs_prev)
      line_pos = line_pos + 8'd1;
    hs_prev  = hs_low;
  endtask

  task automatic send_pixel(input vdata_t px, input logic vld);
    @(posedge VCLK_Tx);
    #2;
    pixel_i       = px;
    pixel_valid_i = vld;
    if (vld) begin
      exp_q.push_back(expected_output(px));
      update_position(px.sync);
    end
  endtask

  // Sends n valid random pixels with optional random idle gaps
  task automatic send_random(input int n, input bit gaps);
    int sent;
    logic vld;
    sent = 0;
    while (sent < n) begin
      vld = gaps ? ($urandom_range(0, 3) != 0) : 1'b1;
      send_pixel(vdata_t'($urandom), vld);
      if (vld)
        sent++;
    end
  endtask

  // Frame of 22 lines with vsync on the first two and a 4 pixel hsync run opening each line
  task automatic send_frame();
    sync_t s;
    logic  vs, hs;
    for (int ln = 0; ln < 22; ln++) begin
      for (int p = 0; p < 24; p++) begin
        vs = (ln >= 2);
        hs = (p >= 4);
        s  = {vs, 1'b1, hs, vs & hs};
        send_pixel({s, 24'($urandom)}, 1'b1);
      end
    end
  endtask

  task automatic drain();
    @(posedge VCLK_Tx);
    #2;
    pixel_valid_i = 1'b0;
    while (exp_q.size() != 0)
      @(posedge VCLK_Tx);
  endtask

  // Change settings on an idle stream and check status once the decode has settled
  task automatic set_config(input cfg_word_t c, input vinfo_t v, input logic vpll);
    logic [9:0] st;
    drain();
    @(posedge VCLK_Tx);
    #2;
    cfg_i      = c;
    vinfo_i    = v;
    use_vpll_i = vpll;
    cur_cfg    = c;
    cur_vinfo  = v;
    cur_vpll   = vpll;
    repeat (3) @(posedge VCLK_Tx);
    #2;
    st = ref_decode(c, v.palmode, v.mode_480i, vpll);
    check_value(ppu_state_o, st, "status word");
    check_value(vclk_tx_select_o, st[7:6], "clock select");
  endtask

  // ----------------------------------------------------------------------
  // Output comparison at the falling edge where outputs are stable
  // ----------------------------------------------------------------------
  always @(negedge VCLK_Tx) begin
    if (nVRST_Tx) begin
      check_value(vd_valid_o, vld_hist[4], "output valid");
      if (vd_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Output pixel arrived with no expected pixel pending at %0t ns", $time);
          $display("Regression failed");
          $fatal(1, "stopping on first error");
        end else begin
          exp_cur = exp_q.pop_front();
          check_value(vd_o, exp_cur.vd, "vd_o");
          check_value(ncsync_o, exp_cur.ncsync, "ncsync_o");
          check_value({nvsync_or_f2_o, nhsync_or_f1_o}, {exp_cur.nv, exp_cur.nh},
                      "shared pins");
        end
      end
    end
    // Input valid as seen by the next rising edge
    vld_hist = {vld_hist[3:0], pixel_valid_i};
  end

  always @(posedge VCLK_Tx) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $fatal(1, "stopping on timeout");
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    cfg_word_t w;
    void'($urandom(32'hc08d));
    VCLK_Tx       = 1'b0;
    nVRST_Tx      = 1'b0;
    pixel_i       = '0;
    pixel_valid_i = 1'b0;
    cfg_i         = '0;
    vinfo_i       = '0;
    use_vpll_i    = 1'b1;
    cur_cfg       = '0;
    cur_vinfo     = '0;
    cur_vpll      = 1'b1;
    pix_pos       = '0;
    line_pos      = '0;
    hs_prev       = 1'b0;
    vld_hist      = '0;
    repeat (10) @(posedge VCLK_Tx);
    #2;
    nVRST_Tx = 1'b1;

    // Plain RGB with valid gaps
    set_config('0, '0, 1'b1);
    send_random(500, 1'b1);
    // Red/blue exchange with sync on green off and then on
    set_config(cfg_word_t'(1) << CFG_SWAP_RB_BIT, '0, 1'b1);
    send_random(100, 1'b1);
    set_config((cfg_word_t'(1) << CFG_SWAP_RB_BIT) | (cfg_word_t'(1) << CFG_RGSB_BIT), '0, 1'b1);
    send_random(100, 1'b1);
    // YPbPr matrix
    set_config(cfg_word_t'(1) << CFG_YPBPR_BIT, '0, 1'b1);
    send_random(500, 1'b0);
    // Checkerboard over a structured frame
    set_config(cfg_word_t'(1) << CFG_TESTPAT_BIT, '0, 1'b1);
    send_frame();

    // Shared pins as VGA sync and then as filter select
    set_config(cfg_word_t'(1) << CFG_USE_VGA_SYNC_BIT, '0, 1'b1);
    send_random(60, 1'b1);
    // Auto filter follows x3
    set_config(cfg_word_t'(2) << CFG_LM240_LSB, '0, 1'b1);
    send_random(60, 1'b0);
    set_config((cfg_word_t'(2) << CFG_LM240_LSB) | (cfg_word_t'(3) << CFG_FILTER_LSB), '0, 1'b1);
    send_random(60, 1'b0);
    set_config(cfg_word_t'(1) << CFG_LX480_BIT, 2'b01, 1'b1);
    send_random(60, 1'b0);

    // Every decode combination with the other bits random
    for (int i = 0; i < 1024; i++) begin
      w = cfg_word_t'($urandom);
      w[CFG_TESTPAT_BIT]       = i[6];
      w[CFG_LX480_BIT]         = i[5];
      w[CFG_LM240_LSB +: 2]    = i[4:3];
      w[CFG_FILTER_LSB +: 3]   = i[9:7];
      set_config(w, {i[0], i[1]}, i[2]);
    end

    drain();
    repeat (3) @(posedge VCLK_Tx);
    if (exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Expected pixels still pending at the end of the run");
      $display("Regression failed");
      $fatal(1, "stopping on missing output");
    end
  end

endmodule

// ==== build.f ====
+incdir+tests
hdl/ppu_tx_pkg.sv
hdl/ppu_tx_cfg_ctrl.sv
hdl/ppu_tx_pattern.sv
hdl/ppu_tx_vconv.sv
hdl/ppu_tx_vout.sv
hdl/ppu_tx_top.sv
tests/ppu_tx_tb.sv
